// ==== video_crop_pkg.sv ====
////////////////////////////////////////////////////////////
// video crop shared types and constants
// coordinates, resolution code, snapshot flag, key codes
// and the crop step sizes used by the border cropping logic
////////////////////////////////////////////////////////////
`default_nettype none

package video_crop_pkg;

	// pixel/line count or crop offset
	typedef logic [11:0] coord_t;

	// core resolution code
	typedef logic [1:0] res_t;

	// snapshot change counter, wraps
	typedef logic [6:0] scr_flg_t;

	// keyboard event type tag
	typedef logic [1:0] kbd_type_t;

	localparam kbd_type_t KBD_TYPE_KEY = 2'd3; // keycode event

	// keycodes acted on by the crop control
	typedef enum logic [7:0] {
		KEY_BACKSPACE = 8'h41,
		KEY_UP        = 8'h4c,
		KEY_DOWN      = 8'h4d,
		KEY_RIGHT     = 8'h4e,
		KEY_LEFT      = 8'h4f,
		KEY_LALT      = 8'h64,
		KEY_RALT      = 8'h65,
		KEY_LALT_UP   = 8'he4, // release codes have bit 7 set
		KEY_RALT_UP   = 8'he5
	} key_code_e;

	localparam coord_t HCROP_STEP    = 12'd4; // pixels per key press
	localparam coord_t VCROP_STEP    = 12'd1; // lines per key press
	localparam coord_t SHBL_LEAD     = 12'd2; // trimmed h edges come early
	localparam coord_t FVBL_SYNC_LAG = 12'd2; // lines after vsync end

endpackage

`default_nettype wire

// ==== crop_key_ctrl.sv ====
////////////////////////////////////////////////////////////
// crop offset control
// turns keyboard events and host preset loads into the
// four border offsets
////////////////////////////////////////////////////////////
`default_nettype none

module crop_key_ctrl (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      kbd_level,
	input  video_crop_pkg::kbd_type_t kbd_type,
	input  logic [7:0]                kbd_data,
	input  logic                      sset,
	input  video_crop_pkg::coord_t    preset_hbl_l,
	input  video_crop_pkg::coord_t    preset_hbl_r,
	input  video_crop_pkg::coord_t    preset_vbl_t,
	input  video_crop_pkg::coord_t    preset_vbl_b,
	output video_crop_pkg::coord_t    hbl_l,
	output video_crop_pkg::coord_t    hbl_r,
	output video_crop_pkg::coord_t    vbl_t,
	output video_crop_pkg::coord_t    vbl_b
);
	import video_crop_pkg::*;

	logic       old_level;
	logic       evt_vld;   // keycode event waiting to be applied
	logic [7:0] evt_code;
	logic       alt;       // either alt key held

	// toggle detect, event is acted on one cycle later
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_level <= 1'b0;
			evt_vld   <= 1'b0;
			evt_code  <= 8'h00;
		end else begin
			old_level <= kbd_level;
			evt_vld   <= (old_level != kbd_level) && (kbd_type == KBD_TYPE_KEY);
			evt_code  <= kbd_data;
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			hbl_l <= '0;
			hbl_r <= '0;
			vbl_t <= '0;
			vbl_b <= '0;
			alt   <= 1'b0;
		end else if (sset) begin // preset wins over a key
			hbl_l <= preset_hbl_l;
			hbl_r <= preset_hbl_r;
			vbl_t <= preset_vbl_t;
			vbl_b <= preset_vbl_b;
		end else if (evt_vld) begin
			case (key_code_e'(evt_code))
				KEY_BACKSPACE: begin
					hbl_l <= '0;
					hbl_r <= '0;
					vbl_t <= '0;
					vbl_b <= '0;
				end
				KEY_UP: begin
					if (alt) vbl_b <= vbl_b + VCROP_STEP;
					else     vbl_t <= vbl_t + VCROP_STEP;
				end
				KEY_DOWN: begin
					if (alt) vbl_b <= vbl_b - VCROP_STEP;
					else     vbl_t <= vbl_t - VCROP_STEP;
				end
				KEY_LEFT: begin
					if (alt) hbl_r <= hbl_r + HCROP_STEP;
					else     hbl_l <= hbl_l + HCROP_STEP;
				end
				KEY_RIGHT: begin
					if (alt) hbl_r <= hbl_r - HCROP_STEP;
					else     hbl_l <= hbl_l - HCROP_STEP;
				end
				KEY_LALT, KEY_RALT:       alt <= 1'b1;
				KEY_LALT_UP, KEY_RALT_UP: alt <= 1'b0;
				default: ; // other keys ignored
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hblank_gen.sv ====
////////////////////////////////////////////////////////////
// horizontal blank generator
// pixel counter with edge capture, trimmed and forced
// horizontal blank, active width measurement
////////////////////////////////////////////////////////////
`default_nettype none

module hblank_gen #(
	parameter int FBL_MARGIN = 8
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   hs,
	input  logic                   hblank,
	input  logic                   first_line,
	input  video_crop_pkg::coord_t hbl_l,
	input  video_crop_pkg::coord_t hbl_r,
	output logic                   hbl,
	output video_crop_pkg::coord_t hsize
);
	import video_crop_pkg::*;

	localparam coord_t MARGIN = coord_t'(FBL_MARGIN);

	logic   old_hs;
	logic   old_hblank;
	coord_t hcnt;  // pixels since end of hsync
	coord_t hend;  // start of active video
	coord_t hsta;  // end of active video
	coord_t hmax;  // line length
	logic   shbl;  // trimmed blank
	logic   fhbl;  // forced blank at line ends

	assign hbl = fhbl | shbl | ~hs;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_hs     <= 1'b1;
			old_hblank <= 1'b0;
			hcnt       <= '0;
			hend       <= '0;
			hsta       <= '0;
			hmax       <= '0;
			shbl       <= 1'b1; // blank until the first line is seen
			fhbl       <= 1'b1;
			hsize      <= '0;
		end else begin
			old_hs     <= hs;
			old_hblank <= hblank;

			if (~hs) hcnt <= '0;
			else     hcnt <= hcnt + 12'd1;

			if (old_hblank & ~hblank) hend <= hcnt;
			if (~old_hblank & hblank) hsta <= hcnt;
			if (old_hs & ~hs)         hmax <= hcnt;

			// edges come SHBL_LEAD early to cover the registered hde
			if (hcnt == hend + hbl_l - SHBL_LEAD) shbl <= 1'b0;
			if (hcnt == hsta + hbl_r - SHBL_LEAD) shbl <= 1'b1;

			if (hcnt == MARGIN)        fhbl <= 1'b0;
			if (hcnt == hmax - MARGIN) fhbl <= 1'b1;

			if (~old_hblank & hblank & first_line) hsize <= hcnt - hend;
		end
	end

endmodule

`default_nettype wire

// ==== vblank_gen.sv ====
////////////////////////////////////////////////////////////
// vertical blank generator
// line counter with edge capture, trimmed and forced
// vertical blank, height measurement, hde/vde outputs
////////////////////////////////////////////////////////////
`default_nettype none

module vblank_gen (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   hs,
	input  logic                   vs,
	input  logic                   vblank,
	input  logic                   hbl,
	input  video_crop_pkg::coord_t vbl_t,
	input  video_crop_pkg::coord_t vbl_b,
	output logic                   first_line,
	output logic                   hde,
	output logic                   vde,
	output video_crop_pkg::coord_t vsize
);
	import video_crop_pkg::*;

	logic   vbl;      // effective vblank, includes vsync
	logic   old_vs;
	logic   old_hs;
	logic   old_vbl;
	logic   old_hbl;
	coord_t vcnt;
	coord_t vend;     // first active line
	coord_t vmax;     // lines per frame
	coord_t vs_end;   // line where vsync ended
	coord_t vbot;     // line where trimmed blank starts
	logic   svbl;
	logic   fvbl;

	assign vbl        = vblank | ~vs;
	assign first_line = (vcnt == 12'd1);

	// top bit of vbl_b set means offset back from frame end
	assign vbot = vbl_b[11] ? vmax + vbl_b : vbl_b;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_vs  <= 1'b1;
			old_hs  <= 1'b1;
			old_vbl <= 1'b0;
			old_hbl <= 1'b0;
			vcnt    <= '0;
			vend    <= '0;
			vmax    <= '0;
			vs_end  <= '0;
			vsize   <= '0;
			svbl    <= 1'b1;
			fvbl    <= 1'b1;
			hde     <= 1'b0;
			vde     <= 1'b0;
		end else begin
			old_vs  <= vs;
			old_hs  <= hs;
			old_vbl <= vbl;
			old_hbl <= hbl;

			if (old_hs & ~hs)   vcnt <= vcnt + 12'd1;
			if (~old_vbl & vbl) vcnt <= '0;

			if (old_vbl & ~vbl) vend   <= vcnt;
			if (~old_vs & vs)   vs_end <= vcnt;
			if (~old_vbl & vbl) begin
				vmax  <= vcnt;
				vsize <= vcnt - vend;
			end

			// vertical edges move only at the end of horizontal blank
			if ((old_hbl & ~hbl) | (vcnt == 12'd0)) begin
				if (vcnt == vend + vbl_t) svbl <= 1'b0;
				if (vcnt == vbot)         svbl <= 1'b1;

				if (vcnt == vmax - 12'd1)          fvbl <= 1'b1;
				if (vcnt == vs_end + FVBL_SYNC_LAG) fvbl <= 1'b0;
			end

			hde <= ~hbl;
			vde <= ~(fvbl | svbl);
		end
	end

endmodule

`default_nettype wire

// ==== scr_status.sv ====
////////////////////////////////////////////////////////////
// screen status snapshot
// latches offsets, size and resolution once per frame and
// counts frames where the picture format changed
////////////////////////////////////////////////////////////
`default_nettype none

module scr_status (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     vblank_eff,
	input  video_crop_pkg::res_t     res,
	input  video_crop_pkg::coord_t   hsize,
	input  video_crop_pkg::coord_t   vsize,
	input  video_crop_pkg::coord_t   hbl_l,
	input  video_crop_pkg::coord_t   hbl_r,
	input  video_crop_pkg::coord_t   vbl_t,
	input  video_crop_pkg::coord_t   vbl_b,
	output video_crop_pkg::coord_t   scr_hbl_l,
	output video_crop_pkg::coord_t   scr_hbl_r,
	output video_crop_pkg::coord_t   scr_vbl_t,
	output video_crop_pkg::coord_t   scr_vbl_b,
	output video_crop_pkg::coord_t   scr_hsize,
	output video_crop_pkg::coord_t   scr_vsize,
	output video_crop_pkg::res_t     scr_res,
	output video_crop_pkg::scr_flg_t scr_flg
);

	logic old_vbl;
	logic vbl_end;  // one cycle pulse after vblank falls
	logic changed;

	assign changed = (scr_res != res) || (scr_hsize != hsize) || (scr_vsize != vsize);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_vbl   <= 1'b0;
			vbl_end   <= 1'b0;
			scr_hbl_l <= '0;
			scr_hbl_r <= '0;
			scr_vbl_t <= '0;
			scr_vbl_b <= '0;
			scr_hsize <= '0;
			scr_vsize <= '0;
			scr_res   <= '0;
			scr_flg   <= '0;
		end else begin
			old_vbl <= vblank_eff;
			vbl_end <= old_vbl & ~vblank_eff;
			if (vbl_end) begin
				scr_hbl_l <= hbl_l;
				scr_hbl_r <= hbl_r;
				scr_vbl_t <= vbl_t;
				scr_vbl_b <= vbl_b;
				scr_hsize <= hsize;
				scr_vsize <= vsize;
				scr_res   <= res;
				if (changed) scr_flg <= scr_flg + 7'd1; // format changed
			end
		end
	end

endmodule

`default_nettype wire

// ==== video_crop.sv ====
////////////////////////////////////////////////////////////
// display border cropping top level
// key control, blank generators and frame snapshot
////////////////////////////////////////////////////////////
`default_nettype none

module video_crop #(
	parameter int FBL_MARGIN = 8
) (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      hs,
	input  logic                      vs,
	input  logic                      hblank,
	input  logic                      vblank,
	input  video_crop_pkg::res_t      res,
	input  logic                      kbd_level,
	input  video_crop_pkg::kbd_type_t kbd_type,
	input  logic [7:0]                kbd_data,
	input  logic                      sset,
	input  video_crop_pkg::coord_t    preset_hbl_l,
	input  video_crop_pkg::coord_t    preset_hbl_r,
	input  video_crop_pkg::coord_t    preset_vbl_t,
	input  video_crop_pkg::coord_t    preset_vbl_b,
	output logic                      hde,
	output logic                      vde,
	output video_crop_pkg::coord_t    scr_hbl_l,
	output video_crop_pkg::coord_t    scr_hbl_r,
	output video_crop_pkg::coord_t    scr_vbl_t,
	output video_crop_pkg::coord_t    scr_vbl_b,
	output video_crop_pkg::coord_t    scr_hsize,
	output video_crop_pkg::coord_t    scr_vsize,
	output video_crop_pkg::res_t      scr_res,
	output video_crop_pkg::scr_flg_t  scr_flg
);
	import video_crop_pkg::*;

	coord_t hbl_l, hbl_r, vbl_t, vbl_b;
	coord_t hsize, vsize;
	logic   hbl;
	logic   first_line;
	logic   vblank_eff;

	assign vblank_eff = vblank | ~vs; // vsync counts as blank

	crop_key_ctrl crop_key_ctrl_i (
		.clk_sys, .reset, .kbd_level, .kbd_type, .kbd_data, .sset,
		.preset_hbl_l, .preset_hbl_r, .preset_vbl_t, .preset_vbl_b,
		.hbl_l, .hbl_r, .vbl_t, .vbl_b
	);

	hblank_gen #(.FBL_MARGIN(FBL_MARGIN)) hblank_gen_i (
		.clk_sys, .reset, .hs, .hblank, .first_line,
		.hbl_l, .hbl_r, .hbl, .hsize
	);

	vblank_gen vblank_gen_i (
		.clk_sys, .reset, .hs, .vs, .vblank, .hbl,
		.vbl_t, .vbl_b, .first_line, .hde, .vde, .vsize
	);

	scr_status scr_status_i (
		.clk_sys, .reset, .vblank_eff, .res, .hsize, .vsize,
		.hbl_l, .hbl_r, .vbl_t, .vbl_b,
		.scr_hbl_l, .scr_hbl_r, .scr_vbl_t, .scr_vbl_b,
		.scr_hsize, .scr_vsize, .scr_res, .scr_flg
	);

endmodule

`default_nettype wire

// ==== tb_video_crop.sv ====
////////////////////////////////////////////////////////////
// testbench for the display border cropping block
// raster generator, stimulus table with expected snapshots,
// hde/vde window measurement and a cycle timeout
////////////////////////////////////////////////////////////
`default_nettype none

module tb_video_crop;
	import video_crop_pkg::*;

	localparam int NROWS   = 12;
	localparam int NMODES  = 3;
	localparam int MAX_FRM = 88 * 14;                   // longest frame in cycles
	localparam int LIMIT   = (NROWS * 3 + 8) * MAX_FRM + 500;

	logic      clk_sys = 1'b0;
	logic      reset;
	logic      hs, vs, hblank, vblank;
	res_t      res;
	logic      kbd_level;
	kbd_type_t kbd_type;
	logic [7:0] kbd_data;
	logic      sset;
	coord_t    preset_hbl_l, preset_hbl_r, preset_vbl_t, preset_vbl_b;
	logic      hde, vde;
	coord_t    scr_hbl_l, scr_hbl_r, scr_vbl_t, scr_vbl_b, scr_hsize, scr_vsize;
	res_t      scr_res;
	scr_flg_t  scr_flg;

	// raster modes: line length, active width, frame lines, active lines, res
	int m_htot [NMODES] = '{72, 88, 72};
	int m_w    [NMODES] = '{40, 48, 40};
	int m_vtot [NMODES] = '{12, 14, 12};
	int m_act  [NMODES] = '{8, 10, 8};
	int m_res  [NMODES] = '{0, 1, 2};

	// stimulus table, kind 0 key, 1 preset, 2 random ignored key
	int         row_kind [NROWS];
	kbd_type_t  row_type [NROWS];
	logic [7:0] row_code [NROWS];
	int         row_mode [NROWS];
	coord_t     exp_hl [NROWS], exp_hr [NROWS], exp_vt [NROWS], exp_vb [NROWS];
	scr_flg_t   exp_flg [NROWS];
	int         nrows = 0;

	logic [31:0] seed = 32'h59cf;
	int          cycles = 0;
	coord_t      hde_cnt, vde_lines, h0, h1, v0, v1;

	video_crop #(.FBL_MARGIN(8)) video_crop_i (.*);

	always #20 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles > LIMIT) begin
			$display("simulation timed out after %0d cycles", cycles);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic is_known(input logic [7:0] c);
		return c inside {8'h41, 8'h4c, 8'h4d, 8'h4e, 8'h4f, 8'h64, 8'h65, 8'he4, 8'he5};
	endfunction

	task automatic check_coord(input string name, input coord_t exp_v, input coord_t act);
		if (exp_v !== act) begin
			$display("Fail %s expected %0d actual %0d", name, exp_v, act);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_res(input string name, input res_t exp_v, input res_t act);
		if (exp_v !== act) begin
			$display("Fail %s expected %0d actual %0d", name, exp_v, act);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_flg(input string name, input scr_flg_t exp_v, input scr_flg_t act);
		if (exp_v !== act) begin
			$display("Fail %s expected %0d actual %0d", name, exp_v, act);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	task automatic add_row(input int kind, input kbd_type_t t, input logic [7:0] c,
			input int mode, input int hl, input int hr, input int vt, input int vb,
			input int flg);
		row_kind[nrows] = kind;
		row_type[nrows] = t;
		row_code[nrows] = c;
		row_mode[nrows] = mode;
		exp_hl[nrows]   = coord_t'(hl);
		exp_hr[nrows]   = coord_t'(hr);
		exp_vt[nrows]   = coord_t'(vt);
		exp_vb[nrows]   = coord_t'(vb);
		exp_flg[nrows]  = scr_flg_t'(flg);
		nrows++;
	endtask

	task automatic send_key(input kbd_type_t t, input logic [7:0] c);
		@(negedge clk_sys);
		kbd_type = t;
		kbd_data = c;
		@(negedge clk_sys);
		kbd_level = ~kbd_level;
		repeat (3) @(negedge clk_sys); // offset settles 2 cycles after toggle
	endtask

	task automatic load_preset(input coord_t hl, input coord_t hr, input coord_t vt,
			input coord_t vb);
		@(negedge clk_sys);
		preset_hbl_l = hl;
		preset_hbl_r = hr;
		preset_vbl_t = vt;
		preset_vbl_b = vb;
		sset = 1'b1;
		@(negedge clk_sys);
		sset = 1'b0;
	endtask

	// one frame; hsync on pixels 0..7, active from pixel 16, vsync on lines 0..1
	task automatic run_frame(input int m);
		int vb_lines;
		vb_lines = m_vtot[m] - m_act[m];
		hde_cnt = '0;
		vde_lines = '0;
		for (int l = 0; l < m_vtot[m]; l++) begin
			for (int p = 0; p < m_htot[m]; p++) begin
				@(negedge clk_sys);
				if (l == m_vtot[m] / 2 && hde)
					hde_cnt = hde_cnt + 12'd1;
				if (p == m_htot[m] / 2 && vde)
					vde_lines = vde_lines + 12'd1;
				hs     = (p >= 8);
				hblank = !(p >= 16 && p < 16 + m_w[m]);
				vblank = (l < vb_lines);
				vs     = (l >= 2);
				res    = res_t'(m_res[m]);
			end
		end
	endtask

	initial begin
		logic [7:0] code;
		string      tn;
		reset = 1'b1;
		hs = 1'b1;
		vs = 1'b1;
		hblank = 1'b0;
		vblank = 1'b0;
		res = '0;
		kbd_level = 1'b0;
		kbd_type = '0;
		kbd_data = '0;
		sset = 1'b0;
		preset_hbl_l = '0;
		preset_hbl_r = '0;
		preset_vbl_t = '0;
		preset_vbl_b = '0;

		add_row(0, 2'd0, KEY_UP, 0, 0, 0, 0, 0, 2); // not a keycode event
		add_row(0, KBD_TYPE_KEY, KEY_UP, 0, 0, 0, 1, 0, 2);
		add_row(0, KBD_TYPE_KEY, KEY_LEFT, 0, 4, 0, 1, 0, 2);
		add_row(0, KBD_TYPE_KEY, KEY_LALT, 0, 4, 0, 1, 0, 2);
		add_row(0, KBD_TYPE_KEY, KEY_UP, 0, 4, 0, 1, 1, 2);
		add_row(0, KBD_TYPE_KEY, KEY_LEFT, 0, 4, 4, 1, 1, 2);
		add_row(0, KBD_TYPE_KEY, KEY_LALT_UP, 0, 4, 4, 1, 1, 2);
		add_row(0, KBD_TYPE_KEY, KEY_DOWN, 0, 4, 4, 0, 1, 2);
		add_row(2, KBD_TYPE_KEY, 8'h00, 0, 4, 4, 0, 1, 2);
		add_row(0, KBD_TYPE_KEY, KEY_BACKSPACE, 1, 0, 0, 0, 0, 4);
		add_row(1, 2'd0, 8'h00, 2, 8, 12, 2, 1, 6);
		add_row(0, KBD_TYPE_KEY, KEY_RIGHT, 0, 4, 12, 2, 1, 7);

		repeat (4) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);
		check_coord("reset hde", '0, coord_t'(hde));
		check_coord("reset vde", '0, coord_t'(vde));
		check_coord("reset scr_hsize", '0, scr_hsize);
		check_coord("reset scr_vsize", '0, scr_vsize);
		check_coord("reset scr_hbl_l", '0, scr_hbl_l);
		check_coord("reset scr_hbl_r", '0, scr_hbl_r);
		check_coord("reset scr_vbl_t", '0, scr_vbl_t);
		check_coord("reset scr_vbl_b", '0, scr_vbl_b);
		check_res("reset scr_res", '0, scr_res);
		check_flg("reset scr_flg", '0, scr_flg);

		for (int r = 0; r < nrows; r++) begin
			case (row_kind[r])
				1: load_preset(exp_hl[r], exp_hr[r], exp_vt[r], exp_vb[r]);
				2: begin
					do begin
						for (int b = 0; b < 8; b++) begin
							seed = lfsr_step(seed);
							code = {code[6:0], seed[0]};
						end
					end while (is_known(code));
					send_key(row_type[r], code);
				end
				default: send_key(row_type[r], row_code[r]);
			endcase
			run_frame(row_mode[r]);
			run_frame(row_mode[r]);
			tn = $sformatf("row %0d", r);
			check_coord({tn, " scr_hbl_l"}, exp_hl[r], scr_hbl_l);
			check_coord({tn, " scr_hbl_r"}, exp_hr[r], scr_hbl_r);
			check_coord({tn, " scr_vbl_t"}, exp_vt[r], scr_vbl_t);
			check_coord({tn, " scr_vbl_b"}, exp_vb[r], scr_vbl_b);
			check_coord({tn, " scr_hsize"}, coord_t'(m_w[row_mode[r]]), scr_hsize);
			check_coord({tn, " scr_vsize"}, coord_t'(m_act[row_mode[r]]), scr_vsize);
			check_res({tn, " scr_res"}, res_t'(m_res[row_mode[r]]), scr_res);
			check_flg({tn, " scr_flg"}, exp_flg[r], scr_flg);
		end

		// window widths: one left step trims the line, vbl_t trims the frame
		load_preset(12'd4, '0, '0, '0);
		run_frame(0);
		run_frame(0);
		h0 = hde_cnt;
		v0 = vde_lines;
		send_key(KBD_TYPE_KEY, KEY_LEFT);
		run_frame(0);
		run_frame(0);
		h1 = hde_cnt;
		check_coord("hde width after left step", h0 - HCROP_STEP, h1);
		load_preset(12'd8, '0, 12'd2, '0);
		run_frame(0);
		run_frame(0);
		v1 = vde_lines;
		check_coord("vde lines with vbl_t 2", v0 - 12'd2, v1);

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== video_crop.f ====
video_crop_pkg.sv
crop_key_ctrl.sv
hblank_gen.sv
vblank_gen.sv
scr_status.sv
video_crop.sv
tb_video_crop.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the video_crop testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -f video_crop.f --top-module tb_video_crop -o simv
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/simv 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "SIMULATION PASSED"; then
	exit 0
fi
exit 1
